/* logic/mips_params.svh */
//**************************************************
// MIPS pipeline sizing and reset PC
//**************************************************
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_WORD_W       32            // data and instruction width
`define MIPS_REG_ADDR_W   5
`define MIPS_NUM_REGS     32

`define MIPS_IMEM_DEPTH   256           // instruction words
`define MIPS_IMEM_ADDR_W  8
`define MIPS_DMEM_DEPTH   256           // data words

`define MIPS_RESET_PC     32'h0040_0000 // text segment base

`endif

/* logic/mips_pkg.sv */
//**************************************************
// MIPS pipeline opcode, funct and ALU encodings
//**************************************************
`default_nettype none

package mips_pkg;

    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [5:0]
    {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2A
    } funct_e;

    typedef enum logic [2:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT                         // signed compare
    } alu_op_e;

endpackage

`default_nettype wire

/* logic/register_file.sv */
//**************************************************
// Register file: 2 read, 1 write, debug read, bypass
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module register_file
(
    input  wire                         SYS_clk,
    input  wire                         wr_en,
    input  wire [`MIPS_REG_ADDR_W-1:0]  wr_addr,
    input  wire [`MIPS_WORD_W-1:0]      wr_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]  rd_addr_a,
    input  wire [`MIPS_REG_ADDR_W-1:0]  rd_addr_b,
    input  wire [`MIPS_REG_ADDR_W-1:0]  dbg_addr,
    output logic [`MIPS_WORD_W-1:0]     rd_data_a,
    output logic [`MIPS_WORD_W-1:0]     rd_data_b,
    output logic [`MIPS_WORD_W-1:0]     dbg_data
);
    logic [`MIPS_WORD_W-1:0] regs [`MIPS_NUM_REGS];

    function automatic logic [`MIPS_WORD_W-1:0] read_reg(
        input logic [`MIPS_REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            return '0;                           // $zero
        else if (wr_en && (wr_addr == addr))
            return wr_data;                      // same-cycle write bypass
        else
            return regs[addr];
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (wr_en && (wr_addr != '0))
            regs[wr_addr] <= wr_data;
    end

    always_comb
    begin
        rd_data_a = read_reg(rd_addr_a);
        rd_data_b = read_reg(rd_addr_b);
        dbg_data  = read_reg(dbg_addr);
    end

endmodule

`default_nettype wire

/* logic/fetch_stage.sv */
//**************************************************
// Fetch: PC register and loadable instruction memory
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module fetch_stage
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire                          core_hold,
    input  wire                          stall,
    input  wire                          redirect,
    input  wire [`MIPS_WORD_W-1:0]       redirect_pc,
    input  wire                          imem_wr_en,
    input  wire [`MIPS_IMEM_ADDR_W-1:0]  imem_wr_addr,
    input  wire [`MIPS_WORD_W-1:0]       imem_wr_data,
    output logic [`MIPS_WORD_W-1:0]      fetch_instr,
    output logic [`MIPS_WORD_W-1:0]      fetch_pc
);
    logic [`MIPS_WORD_W-1:0]      imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_WORD_W-1:0]      pc_offset;
    logic [`MIPS_IMEM_ADDR_W-1:0] imem_idx;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || core_hold)
            fetch_pc <= `MIPS_RESET_PC;
        else if (stall)
            fetch_pc <= fetch_pc;                // hold on hazard
        else if (redirect)
            fetch_pc <= redirect_pc;             // taken branch or jump
        else
            fetch_pc <= fetch_pc + 32'd4;
    end

    // loader port, independent of reset and hold
    always_ff @(posedge SYS_clk)
    begin
        if (imem_wr_en)
            imem[imem_wr_addr] <= imem_wr_data;
    end

    assign pc_offset   = fetch_pc - `MIPS_RESET_PC;
    assign imem_idx    = pc_offset[`MIPS_IMEM_ADDR_W+1:2]; // wraps modulo depth
    assign fetch_instr = core_hold ? '0 : imem[imem_idx]; // bubble while held

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
//**************************************************
// Decode: IF/ID register, control, operand forwarding
// and early branch/jump resolution
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module decode_stage
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire                          core_hold,
    input  wire [`MIPS_WORD_W-1:0]       fetch_instr,
    input  wire [`MIPS_WORD_W-1:0]       fetch_pc,
    input  wire                          stall,
    input  wire                          forward_rs,
    input  wire                          forward_rt,
    input  wire [`MIPS_WORD_W-1:0]       mem_fwd_data,
    input  wire                          wb_reg_write,
    input  wire [`MIPS_REG_ADDR_W-1:0]   wb_dest,
    input  wire [`MIPS_WORD_W-1:0]       wb_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]   dbg_reg_addr,
    output logic [`MIPS_WORD_W-1:0]      dec_instr,
    output logic [`MIPS_WORD_W-1:0]      dec_rs_val,
    output logic [`MIPS_WORD_W-1:0]      dec_rt_val,
    output logic [`MIPS_WORD_W-1:0]      dec_imm,
    output logic [`MIPS_REG_ADDR_W-1:0]  dec_dest,
    output logic                         dec_reg_write,
    output logic                         dec_mem_read,
    output logic                         dec_mem_write,
    output logic                         dec_mem_to_reg,
    output logic                         dec_alu_src_imm,
    output logic                         redirect,
    output logic [`MIPS_WORD_W-1:0]      redirect_pc,
    output logic [`MIPS_WORD_W-1:0]      dbg_reg_data
);
    logic [`MIPS_WORD_W-1:0] dec_pc;
    logic [`MIPS_WORD_W-1:0] rf_rs_val, rf_rt_val;
    opcode_e                 opcode;
    logic                    is_beq, is_bne, is_jump, take_branch;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || core_hold || redirect)
            dec_instr <= '0;                     // kill slot behind branch/jump
        else if (!stall)
            dec_instr <= fetch_instr;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            dec_pc <= fetch_pc;
    end

    assign opcode = opcode_e'(dec_instr[31:26]);

    always_comb
    begin
        dec_reg_write   = 1'b0;
        dec_mem_read    = 1'b0;
        dec_mem_write   = 1'b0;
        dec_mem_to_reg  = 1'b0;
        dec_alu_src_imm = 1'b0;
        dec_dest        = dec_instr[20:16];      // rt unless R-type
        is_beq          = 1'b0;
        is_bne          = 1'b0;
        is_jump         = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                dec_reg_write = 1'b1;
                dec_dest      = dec_instr[15:11];
            end
            OP_ADDI:
            begin
                dec_reg_write   = 1'b1;
                dec_alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                dec_reg_write   = 1'b1;
                dec_mem_read    = 1'b1;
                dec_mem_to_reg  = 1'b1;
                dec_alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                dec_mem_write   = 1'b1;
                dec_alu_src_imm = 1'b1;
            end
            OP_BEQ:  is_beq  = 1'b1;
            OP_BNE:  is_bne  = 1'b1;
            OP_J:    is_jump = 1'b1;
            default: dec_dest = '0;              // unknown opcode acts as bubble
        endcase
    end

    register_file i_register_file
    (
        .SYS_clk   (SYS_clk),
        .wr_en     (wb_reg_write),
        .wr_addr   (wb_dest),
        .wr_data   (wb_data),
        .rd_addr_a (dec_instr[25:21]),
        .rd_addr_b (dec_instr[20:16]),
        .dbg_addr  (dbg_reg_addr),
        .rd_data_a (rf_rs_val),
        .rd_data_b (rf_rt_val),
        .dbg_data  (dbg_reg_data)
    );

    assign dec_rs_val = forward_rs ? mem_fwd_data : rf_rs_val;
    assign dec_rt_val = forward_rt ? mem_fwd_data : rf_rt_val;
    assign dec_imm    = {{(`MIPS_WORD_W-16){dec_instr[15]}}, dec_instr[15:0]};

    assign take_branch = (is_beq && (dec_rs_val == dec_rt_val)) ||
                         (is_bne && (dec_rs_val != dec_rt_val));
    assign redirect    = (take_branch || is_jump) && !stall; // operands stale while stalled
    assign redirect_pc = is_jump ? {dec_pc[31:28], dec_instr[25:0], 2'b00}
                                 : dec_pc + 32'd4 + {dec_imm[`MIPS_WORD_W-3:0], 2'b00};

endmodule

`default_nettype wire

/* logic/hazard_unit.sv */
//**************************************************
// Hazard unit: RAW stall level and decode forwarding
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module hazard_unit
    import mips_pkg::*;
(
    input  wire [`MIPS_WORD_W-1:0]      dec_instr,
    input  wire [`MIPS_REG_ADDR_W-1:0]  ex_dest,
    input  wire                         ex_reg_write,
    input  wire                         ex_mem_read,
    input  wire [`MIPS_REG_ADDR_W-1:0]  mem_dest,
    input  wire                         mem_reg_write,
    input  wire                         mem_mem_read,
    output logic                        stall,
    output logic                        forward_rs,
    output logic                        forward_rt
);
    opcode_e                     opcode;
    logic [`MIPS_REG_ADDR_W-1:0] rs, rt;
    logic                        reads_rt;
    logic                        ex_writes;
    logic                        ex_hit_rs, ex_hit_rt;
    logic                        mem_hit_rs, mem_hit_rt;

    assign opcode = opcode_e'(dec_instr[31:26]);
    assign rs     = dec_instr[25:21];
    assign rt     = dec_instr[20:16];

    // rs is always treated as a source
    assign reads_rt = (opcode == OP_RTYPE) || (opcode == OP_BEQ) ||
                      (opcode == OP_BNE)   || (opcode == OP_SW);

    assign ex_writes  = ex_reg_write || ex_mem_read; // a load always writes
    assign ex_hit_rs  = ex_writes && (ex_dest != '0) && (ex_dest == rs);
    assign ex_hit_rt  = ex_writes && (ex_dest != '0) && (ex_dest == rt) && reads_rt;
    assign mem_hit_rs = mem_reg_write && (mem_dest != '0) && (mem_dest == rs);
    assign mem_hit_rt = mem_reg_write && (mem_dest != '0) && (mem_dest == rt) && reads_rt;

    // result not ready yet in execute, or load data not ready in memory
    assign stall = ex_hit_rs || ex_hit_rt ||
                   (mem_mem_read && (mem_hit_rs || mem_hit_rt));

    assign forward_rs = mem_hit_rs && !mem_mem_read && !stall;
    assign forward_rt = mem_hit_rt && !mem_mem_read && !stall;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
//**************************************************
// Execute: ID/EX register, ALU control and ALU
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module execute_stage
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire                          stall,
    input  wire [`MIPS_WORD_W-1:0]       dec_instr,
    input  wire [`MIPS_WORD_W-1:0]       dec_rs_val,
    input  wire [`MIPS_WORD_W-1:0]       dec_rt_val,
    input  wire [`MIPS_WORD_W-1:0]       dec_imm,
    input  wire [`MIPS_REG_ADDR_W-1:0]   dec_dest,
    input  wire                          dec_reg_write,
    input  wire                          dec_mem_read,
    input  wire                          dec_mem_write,
    input  wire                          dec_mem_to_reg,
    input  wire                          dec_alu_src_imm,
    output logic [`MIPS_WORD_W-1:0]      ex_alu_result,
    output logic [`MIPS_WORD_W-1:0]      ex_store_data,
    output logic [`MIPS_REG_ADDR_W-1:0]  ex_dest,
    output logic                         ex_reg_write,
    output logic                         ex_mem_read,
    output logic                         ex_mem_write,
    output logic                         ex_mem_to_reg
);
    logic [`MIPS_WORD_W-1:0] ex_instr, ex_rs_val, ex_imm;
    logic [`MIPS_WORD_W-1:0] alu_b;
    logic                    ex_alu_src_imm;
    alu_op_e                 alu_op;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset || stall)
        begin
            ex_dest        <= '0;                // bubble
            ex_reg_write   <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_mem_to_reg  <= 1'b0;
            ex_alu_src_imm <= 1'b0;
        end
        else
        begin
            ex_dest        <= dec_dest;
            ex_reg_write   <= dec_reg_write;
            ex_mem_read    <= dec_mem_read;
            ex_mem_write   <= dec_mem_write;
            ex_mem_to_reg  <= dec_mem_to_reg;
            ex_alu_src_imm <= dec_alu_src_imm;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        ex_instr      <= dec_instr;
        ex_rs_val     <= dec_rs_val;
        ex_store_data <= dec_rt_val;
        ex_imm        <= dec_imm;
    end

    always_comb
    begin
        alu_op = ALU_ADD;                        // addi, lw, sw and branches
        if (opcode_e'(ex_instr[31:26]) == OP_RTYPE)
        begin
            case (funct_e'(ex_instr[5:0]))
                F_SUB:   alu_op = ALU_SUB;
                F_AND:   alu_op = ALU_AND;
                F_OR:    alu_op = ALU_OR;
                F_SLT:   alu_op = ALU_SLT;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    assign alu_b = ex_alu_src_imm ? ex_imm : ex_store_data;

    always_comb
    begin
        case (alu_op)
            ALU_SUB: ex_alu_result = ex_rs_val - alu_b;
            ALU_AND: ex_alu_result = ex_rs_val & alu_b;
            ALU_OR:  ex_alu_result = ex_rs_val | alu_b;
            ALU_SLT: ex_alu_result = {{(`MIPS_WORD_W-1){1'b0}},
                                      ($signed(ex_rs_val) < $signed(alu_b))};
            default: ex_alu_result = ex_rs_val + alu_b;
        endcase
    end

endmodule

`default_nettype wire

/* logic/memory_stage.sv */
//**************************************************
// Memory: EX/MEM register and word-addressed data RAM
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module memory_stage
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire [`MIPS_WORD_W-1:0]       ex_alu_result,
    input  wire [`MIPS_WORD_W-1:0]       ex_store_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]   ex_dest,
    input  wire                          ex_reg_write,
    input  wire                          ex_mem_read,
    input  wire                          ex_mem_write,
    input  wire                          ex_mem_to_reg,
    output logic [`MIPS_WORD_W-1:0]      mem_alu_result,
    output logic [`MIPS_WORD_W-1:0]      mem_load_data,
    output logic [`MIPS_REG_ADDR_W-1:0]  mem_dest,
    output logic                         mem_reg_write,
    output logic                         mem_mem_read,
    output logic                         mem_mem_to_reg
);
    localparam int DMEM_ADDR_W = $clog2(`MIPS_DMEM_DEPTH);

    logic [`MIPS_WORD_W-1:0] dmem [`MIPS_DMEM_DEPTH];
    logic [`MIPS_WORD_W-1:0] mem_store_data;
    logic                    mem_mem_write;
    logic [DMEM_ADDR_W-1:0]  dmem_idx;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            mem_dest       <= '0;
            mem_reg_write  <= 1'b0;
            mem_mem_read   <= 1'b0;
            mem_mem_write  <= 1'b0;
            mem_mem_to_reg <= 1'b0;
        end
        else
        begin
            mem_dest       <= ex_dest;
            mem_reg_write  <= ex_reg_write;
            mem_mem_read   <= ex_mem_read;
            mem_mem_write  <= ex_mem_write;
            mem_mem_to_reg <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= ex_alu_result;
        mem_store_data <= ex_store_data;
    end

    assign dmem_idx = mem_alu_result[DMEM_ADDR_W+1:2]; // byte address to word

    always_ff @(posedge SYS_clk)
    begin
        if (mem_mem_write)
            dmem[dmem_idx] <= mem_store_data;
    end

    assign mem_load_data = dmem[dmem_idx];

endmodule

`default_nettype wire

/* logic/writeback_stage.sv */
//**************************************************
// Writeback: MEM/WB register and result select
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module writeback_stage
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire [`MIPS_WORD_W-1:0]       mem_alu_result,
    input  wire [`MIPS_WORD_W-1:0]       mem_load_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]   mem_dest,
    input  wire                          mem_reg_write,
    input  wire                          mem_mem_to_reg,
    output logic                         wb_reg_write,
    output logic [`MIPS_REG_ADDR_W-1:0]  wb_dest,
    output logic [`MIPS_WORD_W-1:0]      wb_data
);
    logic [`MIPS_WORD_W-1:0] wb_alu_result, wb_load_data;
    logic                    wb_mem_to_reg;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wb_reg_write  <= 1'b0;
            wb_dest       <= '0;
            wb_mem_to_reg <= 1'b0;
        end
        else
        begin
            wb_reg_write  <= mem_reg_write;
            wb_dest       <= mem_dest;
            wb_mem_to_reg <= mem_mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        wb_alu_result <= mem_alu_result;
        wb_load_data  <= mem_load_data;
    end

    assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result; // lw vs ALU

endmodule

`default_nettype wire

/* logic/mips_core.sv */
//**************************************************
// MIPS core top: five pipeline stages plus hazard unit
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module mips_core
    import mips_pkg::*;
(
    input  wire                          SYS_clk,
    input  wire                          SYS_reset,
    input  wire                          core_hold,
    input  wire                          imem_wr_en,
    input  wire [`MIPS_IMEM_ADDR_W-1:0]  imem_wr_addr,
    input  wire [`MIPS_WORD_W-1:0]       imem_wr_data,
    input  wire [`MIPS_REG_ADDR_W-1:0]   dbg_reg_addr,
    output logic [`MIPS_WORD_W-1:0]      dbg_reg_data
);
    // fetch <-> decode
    logic [`MIPS_WORD_W-1:0]     fetch_instr, fetch_pc;
    logic                        redirect;
    logic [`MIPS_WORD_W-1:0]     redirect_pc;

    // hazard control
    logic                        stall, forward_rs, forward_rt;

    // decode -> execute
    logic [`MIPS_WORD_W-1:0]     dec_instr, dec_rs_val, dec_rt_val, dec_imm;
    logic [`MIPS_REG_ADDR_W-1:0] dec_dest;
    logic                        dec_reg_write, dec_mem_read, dec_mem_write;
    logic                        dec_mem_to_reg, dec_alu_src_imm;

    // execute -> memory
    logic [`MIPS_WORD_W-1:0]     ex_alu_result, ex_store_data;
    logic [`MIPS_REG_ADDR_W-1:0] ex_dest;
    logic                        ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;

    // memory -> writeback
    logic [`MIPS_WORD_W-1:0]     mem_alu_result, mem_load_data;
    logic [`MIPS_REG_ADDR_W-1:0] mem_dest;
    logic                        mem_reg_write, mem_mem_read, mem_mem_to_reg;

    // writeback -> register file
    logic                        wb_reg_write;
    logic [`MIPS_REG_ADDR_W-1:0] wb_dest;
    logic [`MIPS_WORD_W-1:0]     wb_data;

    fetch_stage i_fetch_stage (.*);

    decode_stage i_decode_stage
    (
        .mem_fwd_data (mem_alu_result), // forward path from memory stage
        .*
    );

    hazard_unit i_hazard_unit (.*);

    execute_stage i_execute_stage (.*);

    memory_stage i_memory_stage (.*);

    writeback_stage i_writeback_stage (.*);

endmodule

`default_nettype wire

/* verif/tb_mips_core.sv */
//**************************************************
// Testbench for mips_core: loads programs from the
// vectors file and checks registers via debug port
//**************************************************
`timescale 1ns/1ps
`default_nettype none
`include "mips_params.svh"

module tb_mips_core;

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRAIN_CYCLES = 4;  // hold cycles so the pipeline empties
    localparam string VECTOR_FILE  = "verif/mips_vectors.txt";

    logic                         SYS_clk;
    logic                         SYS_reset;
    logic                         core_hold;
    logic                         imem_wr_en;
    logic [`MIPS_IMEM_ADDR_W-1:0] imem_wr_addr;
    logic [`MIPS_WORD_W-1:0]      imem_wr_data;
    logic [`MIPS_REG_ADDR_W-1:0]  dbg_reg_addr;
    wire  [`MIPS_WORD_W-1:0]      dbg_reg_data;

    int             error_count     = 0;
    int             check_count     = 0;
    int             watchdog_cycles = 0;
    reg [8*32-1:0]  test_name;

    mips_core i_mips_core
    (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .core_hold    (core_hold),
        .imem_wr_en   (imem_wr_en),
        .imem_wr_addr (imem_wr_addr),
        .imem_wr_data (imem_wr_data),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #(CLK_PERIOD/2) SYS_clk = ~SYS_clk;
    end

    // limit is set once the run lengths are known
    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge SYS_clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

    task automatic check_value(input reg [8*32-1:0] name, input int reg_idx,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED %0s r%0d: expected %h, actual %h",
                     name, reg_idx, expected, actual);
        end
    endtask

    task automatic report_format_error(input logic [7:0] kind);
        error_count++;
        $display("vectors file has a malformed or unknown record '%c'", kind);
    endtask

    // first pass over the file, adds up all R counts
    task automatic sum_run_cycles(input int fd, output int total);
        int             code;
        logic [7:0]     kind;
        logic [31:0]    value;
        reg [8*128-1:0] line_buf;
        total = 0;
        while (!$feof(fd))
        begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1)
            begin
                if (kind == "R")
                begin
                    code  = $fscanf(fd, "%d", value);
                    total += int'(value);
                end
                else
                    code = $fgets(line_buf, fd);  // rest of record or comment
            end
        end
    endtask

    task automatic start_test();
        @(negedge SYS_clk);
        core_hold = 1'b1;
        $display("running test %0s", test_name);
    endtask

    task automatic load_word(input logic [31:0] index, input logic [31:0] word);
        @(negedge SYS_clk);
        imem_wr_en   = 1'b1;
        imem_wr_addr = index[`MIPS_IMEM_ADDR_W-1:0];
        imem_wr_data = word;
    endtask

    task automatic run_program(input int cycles);
        @(negedge SYS_clk);
        imem_wr_en = 1'b0;
        repeat (DRAIN_CYCLES) @(negedge SYS_clk);
        core_hold = 1'b0;
        repeat (cycles) @(negedge SYS_clk);
    endtask

    task automatic check_reg(input logic [31:0] reg_idx, input logic [31:0] expected);
        @(negedge SYS_clk);
        dbg_reg_addr = reg_idx[`MIPS_REG_ADDR_W-1:0];
        @(negedge SYS_clk);                       // program is parked, no writes
        check_value(test_name, int'(reg_idx), expected, dbg_reg_data);
    endtask

    task automatic run_vectors(input int fd);
        int             code;
        logic [7:0]     kind;
        logic [31:0]    value_a;
        logic [31:0]    value_b;
        reg [8*128-1:0] line_buf;
        while (!$feof(fd))
        begin
            code = $fscanf(fd, " %c", kind);
            if (code == 1)
            begin
                case (kind)
                    "#": code = $fgets(line_buf, fd);
                    "T":
                    begin
                        code = $fscanf(fd, "%s", test_name);
                        start_test();
                    end
                    "I":
                    begin
                        code = $fscanf(fd, "%h %h", value_a, value_b);
                        if (code == 2)
                            load_word(value_a, value_b);
                        else
                            report_format_error(kind);
                    end
                    "R":
                    begin
                        code = $fscanf(fd, "%d", value_a);
                        run_program(int'(value_a));
                    end
                    "E":
                    begin
                        code = $fscanf(fd, "%d %h", value_a, value_b);
                        if (code == 2)
                            check_reg(value_a, value_b);
                        else
                            report_format_error(kind);
                    end
                    default: report_format_error(kind);
                endcase
            end
        end
    endtask

    initial
    begin
        int fd;
        int total_run;
        SYS_reset    = 1'b1;
        core_hold    = 1'b1;
        imem_wr_en   = 1'b0;
        imem_wr_addr = '0;
        imem_wr_data = '0;
        dbg_reg_addr = '0;
        test_name    = "none";
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0)
        begin
            $display("cannot open %s for reading", VECTOR_FILE);
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            sum_run_cycles(fd, total_run);
            $fclose(fd);
            watchdog_cycles = 2 * total_run + 200;
            repeat (RESET_CYCLES) @(posedge SYS_clk);
            @(negedge SYS_clk);
            SYS_reset = 1'b0;
            fd = $fopen(VECTOR_FILE, "r");
            run_vectors(fd);
            $fclose(fd);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/mips_pkg.sv
logic/register_file.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/mips_core.sv
verif/tb_mips_core.sv

/* Makefile */
# Verilator build and run for the MIPS pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/mips_vectors.txt */
# T <name> | I <word index hex> <instr hex> | R <cycles dec>
# E <register dec> <expected value hex>; text after # is ignored
T alu_ops
I 00 2001000C  # addi $1,$0,12
I 01 2002FFFB  # addi $2,$0,-5
I 02 00000000
I 03 00000000
I 04 00221820  # add $3,$1,$2
I 05 00000000
I 06 00222022  # sub $4,$1,$2
I 07 00000000
I 08 00222824  # and $5,$1,$2
I 09 00000000
I 0A 00223025  # or $6,$1,$2
I 0B 00000000
I 0C 0041382A  # slt $7,$2,$1
I 0D 0022402A  # slt $8,$1,$2
I 0E 20000007  # addi $0,$0,7
I 0F 1000FFFF  # beq $0,$0,-1 park
R 40
E 0 00000000
E 1 0000000C
E 2 FFFFFFFB
E 3 00000007
E 4 00000011
E 5 00000008
E 6 FFFFFFFF
E 7 00000001
E 8 00000000
T dep_chain
I 00 20010003  # addi $1,$0,3
I 01 20220004  # addi $2,$1,4
I 02 00411820  # add $3,$2,$1
I 03 00622022  # sub $4,$3,$2
I 04 00832825  # or $5,$4,$3
I 05 00A13024  # and $6,$5,$1
I 06 20C7FFFF  # addi $7,$6,-1
I 07 00E5402A  # slt $8,$7,$5
I 08 1000FFFF
R 40
E 1 00000003
E 2 00000007
E 3 0000000A
E 4 00000003
E 5 0000000B
E 6 00000003
E 7 00000002
E 8 00000001
T load_store
I 00 20010040  # addi $1,$0,0x40
I 01 20021234  # addi $2,$0,0x1234
I 02 AC220008  # sw $2,8($1)
I 03 8C230008  # lw $3,8($1)
I 04 00632020  # add $4,$3,$3 load-use
I 05 20650001  # addi $5,$3,1
I 06 1000FFFF
R 40
E 1 00000040
E 2 00001234
E 3 00001234
E 4 00002468
E 5 00001235
T branches
I 00 00005020  # add $10,$0,$0
I 01 00005820  # add $11,$0,$0
I 02 00006020  # add $12,$0,$0
I 03 20010005  # addi $1,$0,5
I 04 20020005  # addi $2,$0,5
I 05 10220002  # beq $1,$2,+2 taken
I 06 200A0001
I 07 200B0001
I 08 20030009  # addi $3,$0,9
I 09 14610001  # bne $3,$1,+1 taken
I 0A 200C0001
I 0B 10230001  # beq $1,$3,+1 not taken
I 0C 20040021
I 0D 14220001  # bne $1,$2,+1 not taken
I 0E 20050022
I 0F 1000FFFF
R 50
E 1 00000005
E 2 00000005
E 3 00000009
E 4 00000021
E 5 00000022
E 10 00000000
E 11 00000000
E 12 00000000
T jump
I 00 20090005  # addi $9,$0,5
I 01 00006820  # add $13,$0,$0
I 02 08100005  # j word 5
I 03 20090063  # killed slot
I 04 200D0001
I 05 212E0001  # addi $14,$9,1
I 06 08100006  # j self
R 30
E 9 00000005
E 13 00000000
E 14 00000006
